/* design/sn_order_pkg.sv */
`default_nettype none

package sn_order_pkg;

  // ------------------------------
  // group geometry
  // ------------------------------
  localparam int SN_W    = 8;    // sequence number width
  localparam int NUM_SN  = 256;  // numbers per group
  localparam int NUM_SLT = 16;   // max slots
  localparam int SLT_W   = 4;
  localparam int MODE_W  = 3;

  typedef enum logic [MODE_W-1:0] {
    sn_16     = 3'd0,  // 16 slots of 16
    sn_32     = 3'd1,
    sn_64     = 3'd2,
    sn_128    = 3'd3,
    sn_256    = 3'd4,  // single slot, whole group
    sn_rsvd_5 = 3'd5,
    sn_rsvd_6 = 3'd6,
    sn_rsvd_7 = 3'd7
  } sn_mode_t;

  // ------------------------------
  // per-mode helpers
  // ------------------------------
  function automatic logic [SN_W:0] slot_size(input sn_mode_t mode);
    case (mode)
      sn_32:   return 32;
      sn_64:   return 64;
      sn_128:  return 128;
      sn_256:  return 256;
      default: return 16;
    endcase
  endfunction

  function automatic logic [SN_W-1:0] slot_mask(input sn_mode_t mode);
    logic [SN_W:0] size_v;
    size_v = slot_size(mode);
    return SN_W'(size_v - 1'b1);
  endfunction

  function automatic logic [SLT_W:0] slot_count(input sn_mode_t mode);
    case (mode)
      sn_32:   return 8;
      sn_64:   return 4;
      sn_128:  return 2;
      sn_256:  return 1;
      default: return 16;
    endcase
  endfunction

  // first number of a slot, slot index folded into the active count
  function automatic logic [SN_W-1:0] slot_base(input sn_mode_t mode,
                                                input logic [SLT_W-1:0] slt);
    logic [SLT_W:0]   cnt;
    logic [SLT_W-1:0] idx;
    cnt = slot_count(mode);
    idx = slt & SLT_W'(cnt - 1'b1);
    return SN_W'(idx * slot_size(mode));
  endfunction

endpackage

`default_nettype wire

/* design/sn_apb_pkg.sv */
`default_nettype none

package sn_apb_pkg;

  localparam int APB_AW = 4;
  localparam int APB_DW = 32;

  // ------------------------------
  // register map
  // ------------------------------
  // mode in [2:0], rw
  localparam logic [APB_AW-1:0] REG_MODE   = 4'h0;
  // [0] sticky duplicate error, write 1 to clear
  localparam logic [APB_AW-1:0] REG_STATUS = 4'h4;

endpackage

`default_nettype wire

/* design/sn_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sn_cfg_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [sn_apb_pkg::APB_AW-1:0] paddr,
  input  logic [sn_apb_pkg::APB_DW-1:0] pwdata,
  input  logic                          dup_hit,
  input  logic                          dup_set,
  output logic [sn_apb_pkg::APB_DW-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output sn_order_pkg::sn_mode_t        mode,
  output logic                          err_any
);
  import sn_order_pkg::*;
  import sn_apb_pkg::*;

  logic     access;
  logic     wr_mode;
  logic     wr_status;
  logic     mode_rsvd;
  sn_mode_t mode_q;
  logic     err_q;

  assign access    = psel & penable;
  assign wr_mode   = access & pwrite & (paddr == REG_MODE);
  assign wr_status = access & pwrite & (paddr == REG_STATUS);
  assign mode_rsvd = pwdata[MODE_W-1:0] > sn_256;  // codes 5..7

  assign pready  = 1'b1;  // zero wait states
  assign pslverr = wr_mode & mode_rsvd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q <= sn_16;
    end else if (wr_mode && !mode_rsvd) begin
      mode_q <= sn_mode_t'(pwdata[MODE_W-1:0]);
    end
  end

  // sticky error, a new hit wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (dup_hit || dup_set) begin
      err_q <= 1'b1;
    end else if (wr_status && pwdata[0]) begin
      err_q <= 1'b0;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      REG_MODE:   prdata[MODE_W-1:0] = mode_q;
      REG_STATUS: prdata[0]          = err_q;
      default:    prdata             = '0;
    endcase
  end

  assign mode    = mode_q;
  assign err_any = err_q;

endmodule

`default_nettype wire

/* design/sn_order_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sn_order_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  sn_order_pkg::sn_mode_t         mode,
  input  logic                           cmp_v,
  input  logic [sn_order_pkg::SN_W-1:0]  cmp_sn,
  input  logic [sn_order_pkg::SLT_W-1:0] cmp_slt,
  input  logic [sn_order_pkg::SN_W-1:0]  slot_shift,
  input  logic                           winner_v,
  input  logic [sn_order_pkg::SLT_W-1:0] winner,
  input  logic                           replay_selected,
  output logic                           cmp_ready,
  output logic [sn_order_pkg::SLT_W-1:0] shift_rd_slt,
  output logic                           update,
  output logic [sn_order_pkg::SLT_W-1:0] update_slt,
  output logic                           set_v,
  output logic [sn_order_pkg::SN_W-1:0]  set_idx,
  output logic                           dup_hit,
  output logic                           replay_v,
  output logic                           replay_sequence_v,
  output logic [sn_order_pkg::SN_W-1:0]  replay_sequence
);
  import sn_order_pkg::*;

  logic             sel_q;      // update cycle flag
  logic [SLT_W-1:0] win_q;
  logic             cmp_acc;
  logic [SN_W-1:0]  mask;
  logic [SLT_W-1:0] cmp_slt_n;  // slot folded into active count
  logic [SN_W-1:0]  local_idx;
  logic             stg_v;
  logic [SLT_W-1:0] stg_slt;
  logic [SN_W-1:0]  stg_idx;
  logic             fwd;
  logic [SN_W-1:0]  stg_idx_adj;

  assign mask      = slot_mask(mode);
  assign cmp_slt_n = cmp_slt & SLT_W'(slot_count(mode) - 1'b1);

  // ------------------------------
  // replay side
  // ------------------------------
  assign update            = sel_q;
  assign update_slt        = win_q;
  assign replay_v          = winner_v & ~sel_q;
  assign replay_sequence_v = sel_q;
  assign replay_sequence   = slot_base(mode, win_q) + slot_shift;  // old shift of winner

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= 1'b0;
      win_q <= '0;
    end else begin
      sel_q <= replay_selected;
      if (replay_selected) win_q <= winner;
    end
  end

  // ------------------------------
  // completion stage
  // ------------------------------
  // the single shift read port is busy in the update cycle
  assign cmp_ready    = ~sel_q;
  assign cmp_acc      = cmp_v & cmp_ready;
  assign shift_rd_slt = sel_q ? win_q : cmp_slt_n;
  assign local_idx    = ((cmp_sn & mask) - slot_shift) & mask;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_v <= 1'b0;
    end else begin
      stg_v <= cmp_acc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_slt <= '0;
      stg_idx <= '0;
    end else if (cmp_acc) begin
      stg_slt <= cmp_slt_n;
      stg_idx <= local_idx;
    end
  end

  // window of the same slot moves down this cycle
  assign fwd         = update & (update_slt == stg_slt);
  assign dup_hit     = stg_v & fwd & (stg_idx == '0);  // head being replayed
  assign set_v       = stg_v & ~dup_hit;
  assign stg_idx_adj = fwd ? stg_idx - 1'b1 : stg_idx;
  assign set_idx     = slot_base(mode, stg_slt) + stg_idx_adj;

  a_sel_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    replay_selected |-> replay_v);

endmodule

`default_nettype wire

/* design/sn_shift_table.sv */
`timescale 1ns/1ps
`default_nettype none

module sn_shift_table (
  input  logic                           clk,
  input  logic                           rst_n,
  input  sn_order_pkg::sn_mode_t         mode,
  input  logic [sn_order_pkg::SLT_W-1:0] rd_slt,
  input  logic                           update,
  input  logic [sn_order_pkg::SLT_W-1:0] update_slt,
  output logic [sn_order_pkg::SN_W-1:0]  rd_shift
);
  import sn_order_pkg::*;

  logic [SN_W-1:0] shift_q [NUM_SLT];
  logic [SN_W-1:0] mask;

  assign mask = slot_mask(mode);

  // ------------------------------
  // shift counters
  // ------------------------------
  // count of numbers already replayed per slot, wraps at slot size
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_SLT; i++) begin
        shift_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_SLT; i++) begin
        if (update && (update_slt == SLT_W'(i))) begin
          shift_q[i] <= (shift_q[i] + 1'b1) & mask;
        end
      end
    end
  end

  assign rd_shift = shift_q[rd_slt];  // no read latency

endmodule

`default_nettype wire

/* design/sn_state_vector.sv */
`timescale 1ns/1ps
`default_nettype none

module sn_state_vector (
  input  logic                           clk,
  input  logic                           rst_n,
  input  sn_order_pkg::sn_mode_t         mode,
  input  logic                           update,
  input  logic [sn_order_pkg::SLT_W-1:0] update_slt,
  input  logic                           set_v,
  input  logic [sn_order_pkg::SN_W-1:0]  set_idx,
  output logic [sn_order_pkg::NUM_SLT-1:0] slot_head,
  output logic                           dup_set
);
  import sn_order_pkg::*;

  logic [NUM_SN-1:0] vec_q;
  logic [NUM_SN-1:0] vec_dn;   // whole vector one bit down
  logic [NUM_SN-1:0] vec_shf;
  logic [NUM_SN-1:0] set_dec;
  logic [SN_W-1:0]   mask;
  logic [SN_W-1:0]   upd_base;

  assign mask     = slot_mask(mode);
  assign upd_base = slot_base(mode, update_slt);
  assign vec_dn   = {1'b0, vec_q[NUM_SN-1:1]};

  // ------------------------------
  // window shift of winning slot
  // ------------------------------
  always_comb begin
    for (int i = 0; i < NUM_SN; i++) begin
      if (update && ((SN_W'(i) & ~mask) == upd_base)) begin
        // top bit of the window takes a zero
        vec_shf[i] = ((SN_W'(i) & mask) == mask) ? 1'b0 : vec_dn[i];
      end else begin
        vec_shf[i] = vec_q[i];
      end
    end
  end

  // set applies against the already shifted window
  assign set_dec = {{(NUM_SN-1){1'b0}}, set_v} << set_idx;
  assign dup_set = |(vec_shf & set_dec);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_q <= '0;
    end else begin
      vec_q <= vec_shf | set_dec;
    end
  end

  // ------------------------------
  // head flags
  // ------------------------------
  always_comb begin
    for (int j = 0; j < NUM_SLT; j++) begin
      if (j < slot_count(mode)) begin
        slot_head[j] = vec_q[slot_base(mode, SLT_W'(j))];
      end else begin
        slot_head[j] = 1'b0;  // slot not used in this mode
      end
    end
  end

endmodule

`default_nettype wire

/* design/slot_rr_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_rr_arb #(
  parameter int NUM_REQS = sn_order_pkg::NUM_SLT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [NUM_REQS-1:0]         reqs,
  input  logic                        update,
  output logic                        winner_v,
  output logic [$clog2(NUM_REQS)-1:0] winner
);

  logic [$clog2(NUM_REQS)-1:0] ptr_q;   // last granted
  logic [$clog2(NUM_REQS)-1:0] last_q;  // winner of the previous cycle

  // search starts one past the last grant
  always_comb begin
    int idx;
    winner_v = 1'b0;
    winner   = '0;
    for (int k = 1; k <= NUM_REQS; k++) begin
      idx = (int'(ptr_q) + k) % NUM_REQS;
      if (!winner_v && reqs[idx]) begin
        winner_v = 1'b1;
        winner   = idx[$clog2(NUM_REQS)-1:0];
      end
    end
  end

  // update follows the select cycle by one, so last_q holds the granted slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q  <= '1;  // first search starts at 0
      last_q <= '0;
    end else begin
      last_q <= winner;
      if (update) ptr_q <= last_q;
    end
  end

  a_update_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
    update |-> $past(winner_v));

endmodule

`default_nettype wire

/* design/sn_order_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sn_order_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // apb
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [sn_apb_pkg::APB_AW-1:0]  paddr,
  input  logic [sn_apb_pkg::APB_DW-1:0]  pwdata,
  output logic [sn_apb_pkg::APB_DW-1:0]  prdata,
  output logic                           pready,
  output logic                           pslverr,
  // completions
  input  logic                           cmp_v,
  input  logic [sn_order_pkg::SN_W-1:0]  cmp_sn,
  input  logic [sn_order_pkg::SLT_W-1:0] cmp_slt,
  output logic                           cmp_ready,
  // replay
  output logic                           replay_v,
  input  logic                           replay_selected,
  output logic                           replay_sequence_v,
  output logic [sn_order_pkg::SN_W-1:0]  replay_sequence,
  output logic                           err_any
);
  import sn_order_pkg::*;

  sn_mode_t         mode;
  logic             dup_hit;
  logic             dup_set;
  logic [SN_W-1:0]  slot_shift;
  logic [SLT_W-1:0] shift_rd_slt;
  logic             winner_v;
  logic [SLT_W-1:0] winner;
  logic             update;
  logic [SLT_W-1:0] update_slt;
  logic             set_v;
  logic [SN_W-1:0]  set_idx;
  logic [NUM_SLT-1:0] slot_head;

  sn_cfg_regs u_cfg (
    .clk, .rst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .dup_hit, .dup_set,
    .prdata, .pready, .pslverr,
    .mode, .err_any
  );

  sn_order_ctrl u_ctrl (
    .clk, .rst_n, .mode,
    .cmp_v, .cmp_sn, .cmp_slt,
    .slot_shift, .winner_v, .winner, .replay_selected,
    .cmp_ready, .shift_rd_slt, .update, .update_slt,
    .set_v, .set_idx, .dup_hit,
    .replay_v, .replay_sequence_v, .replay_sequence
  );

  sn_shift_table u_shift (
    .clk, .rst_n, .mode,
    .rd_slt     (shift_rd_slt),
    .update, .update_slt,
    .rd_shift   (slot_shift)
  );

  sn_state_vector u_vec (
    .clk, .rst_n, .mode,
    .update, .update_slt,
    .set_v, .set_idx,
    .slot_head, .dup_set
  );

  // one request per slot whose oldest number is complete
  slot_rr_arb #(
    .NUM_REQS (NUM_SLT)
  ) u_arb (
    .clk, .rst_n,
    .reqs     (slot_head),
    .update,
    .winner_v, .winner
  );

endmodule

`default_nettype wire

/* test/tb_sn_order.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sn_order;
  import sn_order_pkg::*;
  import sn_apb_pkg::*;

  localparam int N_SCEN  = 6;
  localparam int CLK_PER = 100;

  logic              clk;
  logic              rst_n;
  logic              psel, penable, pwrite, pready, pslverr;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata, prdata, exp_rd;
  logic              cmp_v, cmp_ready, replay_v, replay_selected, replay_sequence_v, err_any;
  logic [SN_W-1:0]   cmp_sn, replay_sequence, exp_seq;
  logic [SLT_W-1:0]  cmp_slt;

  // model keeps absolute numbers as slot base plus number mod slot size
  bit [NUM_SN-1:0] done;
  int              nxt [NUM_SLT];  // next number to replay per slot
  int              last_gnt, exp_slot, n_done, stg_abs;
  bit              stg_v, sel_en;
  logic [2:0]      mode_m;
  logic            err_m, exp_upd, exp_rv, exp_slverr;
  int              seed;
  int              sn_list [NUM_SN];
  int              slt_list [NUM_SN];

  sn_order_top uut (.*);

  initial clk = 1'b0;
  always #(CLK_PER/2) clk = ~clk;

  function automatic int size_of(input logic [2:0] m);
    return 16 << m;  // legal modes only
  endfunction

  function automatic int base_of(input logic [2:0] m, input int s);
    return (s % (NUM_SN / size_of(m))) * size_of(m);
  endfunction

  function automatic bit head_ready(input int s);
    if (s >= NUM_SN / size_of(mode_m)) return 1'b0;
    return done[base_of(mode_m, s) + nxt[s]];
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "value check stopped the run");
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  always @(posedge clk or negedge rst_n) begin : ref_model
    bit dup;
    int s;
    if (!rst_n) begin
      done = '0;
      for (int i = 0; i < NUM_SLT; i++) nxt[i] = 0;
      last_gnt = NUM_SLT - 1;
      exp_slot = 0;
      exp_seq = '0;
      n_done = 0;
      stg_v = 1'b0;
      stg_abs = 0;
      mode_m = 3'd0;
      err_m = 1'b0;
      exp_upd = 1'b0;
      exp_rv = 1'b0;
    end else begin
      if (replay_selected) begin
        // walk down so the nearest ready slot after the last grant wins
        for (int k = NUM_SLT; k >= 1; k--) begin
          s = (last_gnt + k) % NUM_SLT;
          if (head_ready(s)) begin
            exp_slot = s;
            exp_seq = SN_W'(base_of(mode_m, s) + nxt[s]);
          end
        end
      end
      dup = stg_v && done[stg_abs];  // includes the head being replayed
      if (stg_v && !dup) begin
        done[stg_abs] = 1'b1;
        n_done++;
      end
      if (exp_upd) begin
        done[exp_seq] = 1'b0;
        n_done--;
        nxt[exp_slot] = (nxt[exp_slot] + 1) % size_of(mode_m);
        last_gnt = exp_slot;
      end
      stg_v = cmp_v && !exp_upd;
      stg_abs = base_of(mode_m, cmp_slt) + (cmp_sn & (size_of(mode_m) - 1));
      if (dup) err_m = 1'b1;
      else if (psel && penable && pwrite && paddr == REG_STATUS && pwdata[0]) err_m = 1'b0;
      if (psel && penable && pwrite && paddr == REG_MODE && pwdata[2:0] <= 3'd4) begin
        mode_m = pwdata[2:0];
      end
      exp_upd = replay_selected;
      exp_rv = 1'b0;
      for (int i = 0; i < NUM_SLT; i++) begin
        if (head_ready(i)) exp_rv = !exp_upd;
      end
    end
  end

  assign exp_rd = (paddr == REG_MODE) ? APB_DW'(mode_m) :
                  (paddr == REG_STATUS) ? APB_DW'(err_m) : '0;
  assign exp_slverr = psel & penable & pwrite & (paddr == REG_MODE) & (pwdata[2:0] > 3'd4);

  // ------------------------------
  // checks
  // ------------------------------
  a_seq: assert property (@(posedge clk) disable iff (!rst_n)
    replay_sequence_v |-> replay_sequence == exp_seq)
    else report_mismatch("replay_sequence", $sampled(replay_sequence), $sampled(exp_seq));
  a_upd: assert property (@(posedge clk) disable iff (!rst_n) replay_sequence_v == exp_upd)
    else report_mismatch("replay_sequence_v", $sampled(replay_sequence_v), $sampled(exp_upd));
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) cmp_ready == !exp_upd)
    else report_mismatch("cmp_ready", $sampled(cmp_ready), !$sampled(exp_upd));
  a_rv: assert property (@(posedge clk) disable iff (!rst_n) replay_v == exp_rv)
    else report_mismatch("replay_v", $sampled(replay_v), $sampled(exp_rv));
  a_err: assert property (@(posedge clk) disable iff (!rst_n) err_any == err_m)
    else report_mismatch("err_any", $sampled(err_any), $sampled(err_m));
  a_rd: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && !pwrite) |-> prdata == exp_rd)
    else report_mismatch("prdata", $sampled(prdata), $sampled(exp_rd));
  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> pready)
    else report_mismatch("pready", $sampled(pready), 1);
  a_slverr: assert property (@(posedge clk) disable iff (!rst_n) pslverr == exp_slverr)
    else report_mismatch("pslverr", $sampled(pslverr), $sampled(exp_slverr));

  // ------------------------------
  // drivers
  // ------------------------------
  always @(negedge clk) replay_selected = sel_en & replay_v;  // consumer takes every offer

  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr, input int data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = APB_DW'(data);
    @(negedge clk);
    penable = 1'b1;  // zero wait states
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_cmp(input int sn, input int slt);
    @(negedge clk);
    cmp_v = 1'b1;
    cmp_sn = SN_W'(sn);
    cmp_slt = SLT_W'(slt);
    while (!cmp_ready) @(negedge clk);  // held through the update cycle
    @(negedge clk);
    cmp_v = 1'b0;
  endtask

  task automatic send_list(input int n);
    int j;
    int t;
    for (int i = n - 1; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      t = sn_list[i];
      sn_list[i] = sn_list[j];
      sn_list[j] = t;
      t = slt_list[i];
      slt_list[i] = slt_list[j];
      slt_list[j] = t;
    end
    for (int i = 0; i < n; i++) send_cmp(sn_list[i], slt_list[i]);
  endtask

  task automatic consumer(input bit en);
    @(posedge clk);
    sel_en = en;
  endtask

  task automatic drain;
    @(negedge clk);
    while (n_done != 0 || stg_v || exp_upd) @(negedge clk);
  endtask

  initial begin : watchdog
    #(N_SCEN * 2000 * CLK_PER);
    $display("Timeout: the scenarios did not finish within %0d cycles", N_SCEN * 2000);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------
  // scenarios
  // ------------------------------
  initial begin
    seed = 32'h3a6e_9c07;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cmp_v = 1'b0;
    cmp_sn = '0;
    cmp_slt = '0;
    replay_selected = 1'b0;
    sel_en = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    for (int m = 0; m <= 4; m++) begin
      apb_access(1'b1, REG_MODE, m);
      apb_access(1'b0, REG_MODE, 0);
    end
    apb_access(1'b1, REG_MODE, 6);  // reserved code leaves mode 4 in place
    apb_access(1'b0, REG_MODE, 0);

    // mode 4 has one slot of 256 and replay runs alongside
    consumer(1'b1);
    for (int i = 0; i < 256; i++) begin
      sn_list[i] = i;
      slt_list[i] = 0;
    end
    send_list(256);
    drain();

    // mode 0 with all 16 slots ready before the first grant
    consumer(1'b0);
    apb_access(1'b1, REG_MODE, 0);
    for (int i = 0; i < 256; i++) begin
      sn_list[i] = i;
      slt_list[i] = i / 16;
    end
    send_list(256);
    consumer(1'b1);
    drain();

    // mode 3 where the slot 0 shift wraps past 128
    apb_access(1'b1, REG_MODE, 3);
    for (int i = 0; i < 108; i++) begin
      sn_list[i] = (i < 100) ? i : 28 + i;  // tail goes to slot 1
      slt_list[i] = (i < 100) ? 0 : 1;
    end
    send_list(108);
    drain();
    for (int i = 0; i < 100; i++) begin
      sn_list[i] = 100 + i;
      slt_list[i] = 0;
    end
    send_list(100);
    drain();

    // duplicates both plain and at the head in its update cycle
    consumer(1'b0);
    send_cmp(80, 0);
    send_cmp(80, 0);
    apb_access(1'b0, REG_STATUS, 0);
    apb_access(1'b1, REG_STATUS, 1);
    apb_access(1'b0, REG_STATUS, 0);
    send_cmp(136, 1);
    repeat (3) @(negedge clk);
    consumer(1'b1);
    send_cmp(136, 1);  // lands on the select cycle of 136
    for (int i = 0; i < 8; i++) begin
      sn_list[i] = 72 + i;
      slt_list[i] = 0;
    end
    send_list(8);
    drain();
    apb_access(1'b0, REG_STATUS, 0);
    apb_access(1'b1, REG_STATUS, 1);
    apb_access(1'b0, REG_STATUS, 0);

    // completions held off by update cycles
    for (int i = 0; i < 80; i++) begin
      sn_list[i] = (i < 60) ? 81 + i : 77 + i;
      slt_list[i] = (i < 60) ? 0 : 1;
    end
    send_list(80);
    drain();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/sn_order_pkg.sv
design/sn_apb_pkg.sv
design/sn_cfg_regs.sv
design/sn_order_ctrl.sv
design/sn_shift_table.sv
design/sn_state_vector.sv
design/slot_rr_arb.sv
design/sn_order_top.sv
test/tb_sn_order.sv

/* Bender.yml */
package:
  name: sn_order

sources:
  - files:
      - design/sn_order_pkg.sv
      - design/sn_apb_pkg.sv
      - design/sn_cfg_regs.sv
      - design/sn_order_ctrl.sv
      - design/sn_shift_table.sv
      - design/sn_state_vector.sv
      - design/slot_rr_arb.sv
      - design/sn_order_top.sv
  - target: test
    files:
      - test/tb_sn_order.sv
